/* src/stepper_pkg.sv */
package stepper_pkg;

	// the top level takes these widths as the defaults of its parameters.
	localparam int DEF_PULSE_NUM_BITS   = 16; // signed step count.
	localparam int DEF_PULSE_WIDTH_BITS = 8;  // pulse width in ticks.
	localparam int DEF_DIV_BITS         = 8;

	// one axis either sits idle or walks through high and low phases of a pulse.
	typedef enum logic [1:0] {
		AXIS_IDLE,
		AXIS_HIGH,
		AXIS_LOW
	} axis_state_t;

	// the controller waits for a command, then waits for both axes.
	typedef enum logic {
		CTRL_IDLE,
		CTRL_RUN
	} ctrl_state_t;

endpackage : stepper_pkg

/* src/stepper_cmd_if.sv */
`timescale 1ns/100ps

interface stepper_cmd_if #(
	parameter int PULSE_NUM_BITS   = stepper_pkg::DEF_PULSE_NUM_BITS,
	parameter int PULSE_WIDTH_BITS = stepper_pkg::DEF_PULSE_WIDTH_BITS
);
	logic signed [PULSE_NUM_BITS-1:0] pulse_num_x;
	logic signed [PULSE_NUM_BITS-1:0] pulse_num_y;
	logic [PULSE_WIDTH_BITS-1:0]      pulse_width;
	logic                             trigger; // held by the host until rdy drops.
	logic                             rdy;

	modport master (
		output pulse_num_x,
		output pulse_num_y,
		output pulse_width,
		output trigger,
		input  rdy
	);

	modport slave (
		input  pulse_num_x,
		input  pulse_num_y,
		input  pulse_width,
		input  trigger,
		output rdy
	);

endinterface : stepper_cmd_if

/* src/axis_cmd_if.sv */
`timescale 1ns/100ps

interface axis_cmd_if #(
	parameter int PULSE_NUM_BITS   = stepper_pkg::DEF_PULSE_NUM_BITS,
	parameter int PULSE_WIDTH_BITS = stepper_pkg::DEF_PULSE_WIDTH_BITS
);
	logic                             start; // one cycle wide.
	logic signed [PULSE_NUM_BITS-1:0] count;
	logic [PULSE_WIDTH_BITS-1:0]      width;
	logic                             busy;

	modport ctrl (
		output start,
		output count,
		output width,
		input  busy
	);

	modport axis (
		input  start,
		input  count,
		input  width,
		output busy
	);

endinterface : axis_cmd_if

/* src/clk_en_divider.sv */
`timescale 1ns/100ps

module clk_en_divider #(
	parameter int DIV_BITS = stepper_pkg::DEF_DIV_BITS
) (
	input  logic                intf,
	input  logic                arst_n,
	input  logic [DIV_BITS-1:0] div,
	output logic                tick
);

	logic [DIV_BITS-1:0] cnt;

	assign tick = (cnt == '0);

	// the counter runs freely, so the period is div+1 cycles.
	always_ff @(posedge intf or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
		end else if (tick) begin
			cnt <= div;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// with any division at all the tick must be a single cycle wide.
	assert property (@(posedge intf) disable iff (!arst_n)
		(tick && (div != '0)) |=> !tick);

endmodule : clk_en_divider

/* src/step_pulse_gen.sv */
`timescale 1ns/100ps

module step_pulse_gen #(
	parameter int PULSE_NUM_BITS   = stepper_pkg::DEF_PULSE_NUM_BITS,
	parameter int PULSE_WIDTH_BITS = stepper_pkg::DEF_PULSE_WIDTH_BITS
) (
	input  logic     intf,
	input  logic     arst_n,
	input  logic     tick,
	axis_cmd_if.axis cmd,
	output logic     step,
	output logic     dir
);
	import stepper_pkg::*;

	axis_state_t                 state;
	logic [PULSE_NUM_BITS-1:0]   remaining;
	logic [PULSE_NUM_BITS-1:0]   count_mag;
	logic [PULSE_WIDTH_BITS-1:0] width_m1;
	logic [PULSE_WIDTH_BITS-1:0] start_width_m1;
	logic [PULSE_WIDTH_BITS-1:0] tick_cnt;
	logic                        phase_end;

	// the magnitude of the most negative count still fits as an unsigned value.
	assign count_mag = cmd.count[PULSE_NUM_BITS-1] ? $unsigned(-cmd.count)
		: $unsigned(cmd.count);

	assign start_width_m1 = (cmd.width == '0) ? '0 : cmd.width - 1'b1; // zero acts as one.

	assign phase_end = tick && (tick_cnt == width_m1);

	assign cmd.busy = (state != AXIS_IDLE);

	always_ff @(posedge intf) begin
		if ((state == AXIS_IDLE) && cmd.start) begin
			width_m1 <= start_width_m1;
		end
	end

	// a start enters a short low phase that ends at the next tick.
	// Every later low phase either launches the next pulse or finishes the move.
	always_ff @(posedge intf or negedge arst_n) begin
		if (!arst_n) begin
			state     <= AXIS_IDLE;
			remaining <= '0;
			tick_cnt  <= '0;
			step      <= 1'b0;
			dir       <= 1'b0;
		end else begin
			case (state)
			AXIS_IDLE: begin
				if (cmd.start) begin
					state     <= AXIS_LOW;
					remaining <= count_mag;
					tick_cnt  <= start_width_m1;
					dir       <= cmd.count[PULSE_NUM_BITS-1]; // high for negative moves.
				end
			end
			AXIS_HIGH: begin
				if (phase_end) begin
					state    <= AXIS_LOW;
					step     <= 1'b0;
					tick_cnt <= '0;
				end else if (tick) begin
					tick_cnt <= tick_cnt + 1'b1;
				end
			end
			AXIS_LOW: begin
				if (phase_end) begin
					tick_cnt <= '0;
					if (remaining == '0) begin
						state <= AXIS_IDLE;
					end else begin
						state     <= AXIS_HIGH;
						step      <= 1'b1;
						remaining <= remaining - 1'b1;
					end
				end else if (tick) begin
					tick_cnt <= tick_cnt + 1'b1;
				end
			end
			default: begin
				state <= AXIS_IDLE;
				step  <= 1'b0;
			end
			endcase
		end
	end

	assert property (@(posedge intf) disable iff (!arst_n)
		(state == AXIS_IDLE) |-> !step);

	// direction only moves on the start edge, which comes before busy rises.
	assert property (@(posedge intf) disable iff (!arst_n)
		cmd.busy |=> $stable(dir));

endmodule : step_pulse_gen

/* src/stepper_ctrl_xy.sv */
`timescale 1ns/100ps

module stepper_ctrl_xy (
	input  logic         intf,
	input  logic         arst_n,
	stepper_cmd_if.slave host,
	axis_cmd_if.ctrl     axis_x,
	axis_cmd_if.ctrl     axis_y
);
	import stepper_pkg::*;

	ctrl_state_t state;
	logic        accept;
	logic        axes_busy;

	assign host.rdy = (state == CTRL_IDLE);

	// a trigger only counts while ready, so a held trigger is harmless.
	assign accept = host.trigger && host.rdy;

	assign axes_busy = axis_x.busy || axis_y.busy;

	// the axes latch count and width on the start cycle.
	assign axis_x.start = accept;
	assign axis_y.start = accept;
	assign axis_x.count = host.pulse_num_x;
	assign axis_y.count = host.pulse_num_y;
	assign axis_x.width = host.pulse_width;
	assign axis_y.width = host.pulse_width;

	always_ff @(posedge intf or negedge arst_n) begin
		if (!arst_n) begin
			state <= CTRL_IDLE;
		end else begin
			case (state)
			CTRL_IDLE: begin
				if (accept) begin
					state <= CTRL_RUN;
				end
			end
			CTRL_RUN: begin
				// both axes are busy on the first run cycle.
				if (!axes_busy) begin
					state <= CTRL_IDLE;
				end
			end
			default: begin
				state <= CTRL_IDLE;
			end
			endcase
		end
	end

	// a start may only reach axes that have finished the previous move.
	assert property (@(posedge intf) disable iff (!arst_n)
		(axis_x.start || axis_y.start) |-> !axes_busy);

	// the run state relies on both axes answering a start at once.
	assert property (@(posedge intf) disable iff (!arst_n)
		accept |=> (axis_x.busy && axis_y.busy && !host.rdy));

endmodule : stepper_ctrl_xy

/* src/stepper_xy_top.sv */
`timescale 1ns/100ps

module stepper_xy_top #(
	parameter int PULSE_NUM_BITS   = stepper_pkg::DEF_PULSE_NUM_BITS,
	parameter int PULSE_WIDTH_BITS = stepper_pkg::DEF_PULSE_WIDTH_BITS,
	parameter int DIV_BITS         = stepper_pkg::DEF_DIV_BITS
) (
	input  logic                             intf,
	input  logic                             arst_n,
	input  logic [DIV_BITS-1:0]              div,
	input  logic [PULSE_WIDTH_BITS-1:0]      pulse_width,
	input  logic signed [PULSE_NUM_BITS-1:0] pulse_num_x,
	input  logic signed [PULSE_NUM_BITS-1:0] pulse_num_y,
	input  logic                             trigger,
	output logic                             rdy,
	output logic                             out_x,
	output logic                             dir_x,
	output logic                             out_y,
	output logic                             dir_y
);

	logic tick; // shared step time base.

	stepper_cmd_if #(
		.PULSE_NUM_BITS  (PULSE_NUM_BITS),
		.PULSE_WIDTH_BITS(PULSE_WIDTH_BITS)
	) host_if ();

	axis_cmd_if #(
		.PULSE_NUM_BITS  (PULSE_NUM_BITS),
		.PULSE_WIDTH_BITS(PULSE_WIDTH_BITS)
	) axis_x_if ();

	axis_cmd_if #(
		.PULSE_NUM_BITS  (PULSE_NUM_BITS),
		.PULSE_WIDTH_BITS(PULSE_WIDTH_BITS)
	) axis_y_if ();

	assign host_if.pulse_num_x = pulse_num_x;
	assign host_if.pulse_num_y = pulse_num_y;
	assign host_if.pulse_width = pulse_width;
	assign host_if.trigger     = trigger;
	assign rdy                 = host_if.rdy;

	clk_en_divider #(
		.DIV_BITS(DIV_BITS)
	) u_clk_en_divider (
		.intf  (intf),
		.arst_n(arst_n),
		.div   (div),
		.tick  (tick)
	);

	stepper_ctrl_xy u_stepper_ctrl_xy (
		.intf  (intf),
		.arst_n(arst_n),
		.host  (host_if.slave),
		.axis_x(axis_x_if.ctrl),
		.axis_y(axis_y_if.ctrl)
	);

	step_pulse_gen #(
		.PULSE_NUM_BITS  (PULSE_NUM_BITS),
		.PULSE_WIDTH_BITS(PULSE_WIDTH_BITS)
	) u_step_pulse_gen_x (
		.intf  (intf),
		.arst_n(arst_n),
		.tick  (tick),
		.cmd   (axis_x_if.axis),
		.step  (out_x),
		.dir   (dir_x)
	);

	step_pulse_gen #(
		.PULSE_NUM_BITS  (PULSE_NUM_BITS),
		.PULSE_WIDTH_BITS(PULSE_WIDTH_BITS)
	) u_step_pulse_gen_y (
		.intf  (intf),
		.arst_n(arst_n),
		.tick  (tick),
		.cmd   (axis_y_if.axis),
		.step  (out_y),
		.dir   (dir_y)
	);

endmodule : stepper_xy_top

/* sim/step_monitor.sv */
`timescale 1ns/100ps

module step_monitor #(
	parameter int    PULSE_NUM_BITS = stepper_pkg::DEF_PULSE_NUM_BITS,
	parameter string STEP_NAME      = "out_x",
	parameter string DIR_NAME       = "dir_x"
) (
	input  logic                             intf,
	input  logic                             arst_n,
	input  logic                             accept,
	input  logic signed [PULSE_NUM_BITS-1:0] exp_count,
	input  int                               exp_len,
	input  logic                             step,
	input  logic                             dir,
	input  logic                             rdy,
	output logic                             error
);
	int   cyc;
	int   pulses;
	int   mag;
	int   len;
	int   rise_cyc;
	int   fall_cyc;
	logic active;
	logic exp_dir;
	logic prev_step;
	logic prev_rdy;

	initial error = 1'b0;

	task automatic mismatch(input string sig, input int expv, input int gotv);
		$display("[ERROR] %0t %s: expected %0d, got %0d", $time, sig, expv, gotv);
		error = 1'b1;
	endtask

	task automatic complain(input string what);
		$display("[ERROR] %0t %s", $time, what);
		error = 1'b1;
	endtask

	// the DUT updates on the rising edge, so its outputs are read on the falling edge.
	always @(negedge intf) begin
		cyc++;
		if (!arst_n) begin
			active = 1'b0;
		end else begin
			if (active) // dir is set one cycle after acceptance and must hold.
				assert (dir == exp_dir) else mismatch(DIR_NAME, exp_dir, dir);
			if (rdy && !prev_rdy && active) begin
				assert (pulses == mag) else mismatch({STEP_NAME, " pulse count"}, mag, pulses);
				assert (!step) else mismatch(STEP_NAME, 0, step);
				if (mag > 0)
					assert (cyc - fall_cyc > len) else complain($sformatf(
						"rdy rose %0d cycles after the last %s pulse, before its %0d cycle low phase",
						cyc - fall_cyc, STEP_NAME, len));
				active = 1'b0;
			end
			if (step && !prev_step) begin
				assert (active) else complain({STEP_NAME, " pulsed while no move was running"});
				pulses++;
				assert (pulses <= mag) else mismatch({STEP_NAME, " pulse count"}, mag, pulses);
				if (pulses > 1)
					assert (cyc - fall_cyc == len) else
						mismatch({STEP_NAME, " low time"}, len, cyc - fall_cyc);
				rise_cyc = cyc;
			end
			if (!step && prev_step) begin
				assert (cyc - rise_cyc == len) else
					mismatch({STEP_NAME, " high time"}, len, cyc - rise_cyc);
				fall_cyc = cyc;
			end
			if (accept) begin // the next rising edge takes this command.
				active  = 1'b1;
				pulses  = 0;
				mag     = (exp_count < 0) ? -int'(exp_count) : int'(exp_count);
				exp_dir = (exp_count < 0);
				len     = exp_len;
			end
		end
		prev_step = step;
		prev_rdy  = rdy;
	end

endmodule : step_monitor

/* sim/stepper_xy_tb.sv */
`timescale 1ns/100ps

module stepper_xy_tb;
	import stepper_pkg::*;

	localparam int NUM_MOVES  = 13;
	localparam int WORST_MOVE = 2 * 7 * 4 * 3 + 10; // seven pulses, width 4, div 2, plus overhead.
	localparam int MAX_CYCLES = 2 * NUM_MOVES * WORST_MOVE;

	logic                                 intf;
	logic                                 arst_n;
	logic [DEF_DIV_BITS-1:0]              div;
	logic [DEF_PULSE_WIDTH_BITS-1:0]      pulse_width;
	logic signed [DEF_PULSE_NUM_BITS-1:0] pulse_num_x;
	logic signed [DEF_PULSE_NUM_BITS-1:0] pulse_num_y;
	logic                                 trigger;
	logic                                 rdy;
	logic                                 out_x;
	logic                                 dir_x;
	logic                                 out_y;
	logic                                 dir_y;
	logic                                 accept;
	logic                                 accept_d;
	logic                                 err_x;
	logic                                 err_y;
	logic                                 failed;
	logic                                 timed_out;
	int                                   seed;
	int                                   cycles;
	int                                   move_len;

	// each phase lasts width ticks, and a zero width counts as one.
	function automatic int phase_cycles(input int width, input int d);
		return ((width == 0) ? 1 : width) * (d + 1);
	endfunction

	assign accept   = trigger && rdy;
	assign move_len = phase_cycles(pulse_width, div);

	stepper_xy_top u_stepper_xy_top (
		.intf       (intf),
		.arst_n     (arst_n),
		.div        (div),
		.pulse_width(pulse_width),
		.pulse_num_x(pulse_num_x),
		.pulse_num_y(pulse_num_y),
		.trigger    (trigger),
		.rdy        (rdy),
		.out_x      (out_x),
		.dir_x      (dir_x),
		.out_y      (out_y),
		.dir_y      (dir_y)
	);

	step_monitor #(.STEP_NAME("out_x"), .DIR_NAME("dir_x")) mon_x (
		.intf(intf), .arst_n(arst_n), .accept(accept), .exp_count(pulse_num_x),
		.exp_len(move_len), .step(out_x), .dir(dir_x), .rdy(rdy), .error(err_x));

	step_monitor #(.STEP_NAME("out_y"), .DIR_NAME("dir_y")) mon_y (
		.intf(intf), .arst_n(arst_n), .accept(accept), .exp_count(pulse_num_y),
		.exp_len(move_len), .step(out_y), .dir(dir_y), .rdy(rdy), .error(err_y));

	task automatic report_mismatch(input string sig, input int expv, input int gotv);
		$display("[ERROR] %0t %s: expected %0d, got %0d", $time, sig, expv, gotv);
		failed = 1'b1;
	endtask

	// waits for rdy, issues one command and optionally pokes trigger while busy.
	task automatic run_move(input int cx, input int cy, input int w, input int d, input bit poke);
		do @(negedge intf); while (!rdy);
		@(posedge intf);
		div         <= d;
		pulse_width <= w;
		pulse_num_x <= cx;
		pulse_num_y <= cy;
		trigger     <= 1'b1;
		do @(negedge intf); while (rdy);
		@(posedge intf);
		trigger <= 1'b0;
		if (poke && (cx != 0 || cy != 0)) begin // a nonzero move is still busy here.
			@(posedge intf);
			pulse_num_x <= -cx;
			pulse_num_y <= -cy - 1;
			trigger     <= 1'b1;
			@(posedge intf);
			trigger <= 1'b0;
		end
	endtask

	initial begin
		intf = 1'b0;
		forever #5 intf = ~intf;
	end

	always @(posedge intf) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES)
			timed_out <= 1'b1;
	end

	// rdy has to be low on the cycle right after an accepting edge.
	always @(negedge intf) begin
		if (arst_n && accept_d)
			assert (!rdy) else report_mismatch("rdy", 0, rdy);
		accept_d = arst_n && accept;
	end

	initial begin : fail_watch
		wait (failed || err_x || err_y || timed_out);
		if (timed_out)
			$display("run stopped after %0d cycles without finishing the moves", MAX_CYCLES);
		$display("** FAIL **");
		$fatal(1, "stopped at the first failure");
	end

	initial begin : stimulus
		int cx;
		int cy;
		int w;
		int d;
		bit poke;

		seed        = 32'h4b07_fd81;
		arst_n      = 1'b0;
		div         = 1;
		pulse_width = 2;
		pulse_num_x = 0;
		pulse_num_y = 0;
		trigger     = 1'b0;
		failed      = 1'b0;
		timed_out   = 1'b0;
		cycles      = 0;
		accept_d    = 1'b0;
		repeat (3) @(posedge intf);
		arst_n <= 1'b1;
		@(negedge intf);
		assert (rdy) else report_mismatch("rdy", 1, rdy);
		assert (!out_x && !dir_x && !out_y && !dir_y) else
			report_mismatch("{out_x,dir_x,out_y,dir_y}", 0, {out_x, dir_x, out_y, dir_y});

		run_move(-3, 0, 2, 1, 1'b0);
		run_move(-3, 2, 2, 1, 1'b1);
		run_move(0, 2, 2, 1, 1'b0);
		repeat (10) begin
			cx   = $random(seed) % 8; // signed remainder spans -7 to 7.
			cy   = $random(seed) % 8;
			w    = 1 + ($unsigned($random(seed)) % 4);
			d    = $unsigned($random(seed)) % 3;
			poke = ($random(seed) % 2) != 0;
			run_move(cx, cy, w, d, poke);
		end
		do @(negedge intf); while (!rdy);
		@(negedge intf);

		if (failed || err_x || err_y) begin
			$display("** FAIL **");
			$fatal(1, "checks failed");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule : stepper_xy_tb

/* all.f */
src/stepper_pkg.sv
src/stepper_cmd_if.sv
src/axis_cmd_if.sv
src/clk_en_divider.sv
src/step_pulse_gen.sv
src/stepper_ctrl_xy.sv
src/stepper_xy_top.sv
sim/step_monitor.sv
sim/stepper_xy_tb.sv
